//--- hw/rv32v_mem_pkg.sv
// Supports unit-stride vectors of eew 8/16/32 within one 16-byte register and word-aligned banks only
package rv32v_mem_pkg;

    // Bus and bank data word
    typedef logic [31:0] word_t;

    // Vector register file geometry
    localparam int NUM_LANES = 4;
    localparam int LANE_W = 2;
    localparam int WORD_BYTES = 4;
    // Slot index inside a bank word, widest at eew 8
    localparam int SLOT_W = 2;

    // Element count limits
    localparam int VLMAX = 16;
    localparam int VL_W = 5;

    // Access size and extension
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } load_type_e;

    // Vector element width
    typedef enum logic [1:0] {
        EEW8,
        EEW16,
        EEW32
    } eew_e;

    // Scalar writeback source
    typedef enum logic [1:0] {
        WSEL_LOAD,
        WSEL_PC4,
        WSEL_IMMU,
        WSEL_ALU
    } wsel_e;

    // Serializer FSM
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_ISSUE,
        SER_WAIT,
        SER_DONE
    } ser_state_e;

    // Load-store controller FSM
    typedef enum logic [1:0] {
        LSC_IDLE,
        LSC_BUS,
        LSC_DONE
    } lsc_state_e;

endpackage

//--- hw/lsc_if.sv
// Request is a level held until the one-cycle done pulse; one access in flight at a time
`timescale 1ns/1ns

interface lsc_if;
    import rv32v_mem_pkg::*;

    // Request side, from the stage arbiter
    logic ren;
    logic wen;
    word_t addr;
    // Store data sits in the low bits, unshifted
    word_t store_data;
    load_type_e load_type;

    // Response side
    word_t dload_ext;
    logic done;

    // Stage arbiter
    modport arb (
        output ren, wen, addr, store_data, load_type,
        input dload_ext, done
    );

    // Load-store controller
    modport lsc (
        input ren, wen, addr, store_data, load_type,
        output dload_ext, done
    );

endinterface

//--- hw/serial_if.sv
// Vector operands must stay stable from start until done; lane outputs are combinational pulses
`timescale 1ns/1ns

interface serial_if;
    import rv32v_mem_pkg::*;

    // Operation from the stage
    logic start;
    logic vren;
    logic vwen;
    word_t base;
    eew_e eew;
    logic [VL_W-1:0] vl;
    word_t [NUM_LANES-1:0] vstore_data;
    // Per-element completion and its extended load data
    logic elem_done;
    word_t elem_rdata;

    // Element request toward the arbiter
    logic elem_ren;
    logic elem_wen;
    word_t elem_addr;
    word_t elem_store_data;
    load_type_e elem_load_type;

    // Loaded element routed to its bank
    word_t [NUM_LANES-1:0] lane_data;
    logic [NUM_LANES-1:0] lane_wen;
    logic [SLOT_W-1:0] slot;
    logic done;

    modport stage (
        output start, vren, vwen, base, eew, vl, vstore_data, elem_done, elem_rdata,
        input elem_ren, elem_wen, elem_addr, elem_store_data, elem_load_type,
        input lane_data, lane_wen, slot, done
    );

    modport ser (
        input start, vren, vwen, base, eew, vl, vstore_data, elem_done, elem_rdata,
        output elem_ren, elem_wen, elem_addr, elem_store_data, elem_load_type,
        output lane_data, lane_wen, slot, done
    );

endinterface

//--- hw/mem_serializer.sv
// Unit-stride only; loads are zero-extended and vl must not exceed 16/eew-bytes elements
`timescale 1ns/1ns

module mem_serializer (
    input logic CLK,
    input logic rst_n,
    serial_if.ser ser_bus
);
    import rv32v_mem_pkg::*;

    ser_state_e state;
    ser_state_e next_state;
    logic [VL_W-1:0] idx;
    logic [LANE_W-1:0] lane;
    logic [1:0] esize_shift;
    logic [VL_W-1:0] vl_cap;
    logic last_elem;
    logic req;
    word_t bank_word;

    // Element i lives in bank i mod lanes, slot i div lanes
    assign lane = idx[LANE_W-1:0];
    assign ser_bus.slot = idx[LANE_W +: SLOT_W];

    // log2 of element size in bytes
    always_comb begin
        case (ser_bus.eew)
            EEW8: esize_shift = 2'd0;
            EEW16: esize_shift = 2'd1;
            default: esize_shift = 2'd2;
        endcase
    end

    // Register capacity in elements
    assign vl_cap = VL_W'(VLMAX >> esize_shift);
    assign last_elem = (idx == ser_bus.vl - VL_W'(1));

    always_comb begin
        next_state = state;
        case (state)
            SER_IDLE: if (ser_bus.start) next_state = SER_ISSUE;
            // vl of zero falls straight through to done
            SER_ISSUE: next_state = (idx < ser_bus.vl) ? SER_WAIT : SER_DONE;
            SER_WAIT: begin
                if (ser_bus.elem_done) begin
                    next_state = last_elem ? SER_DONE : SER_ISSUE;
                end
            end
            SER_DONE: next_state = SER_IDLE;
            default: next_state = SER_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= SER_IDLE;
            idx <= '0;
        end else begin
            state <= next_state;
            if (state == SER_IDLE) begin
                idx <= '0;
            end else if (state == SER_WAIT && ser_bus.elem_done) begin
                idx <= idx + VL_W'(1);
            end
        end
    end

    // Request held from issue until the controller's done
    assign req = (state == SER_ISSUE && idx < ser_bus.vl) || state == SER_WAIT;
    assign ser_bus.elem_ren = req & ser_bus.vren;
    assign ser_bus.elem_wen = req & ser_bus.vwen;
    assign ser_bus.elem_addr = ser_bus.base + (word_t'(idx) << esize_shift);
    assign ser_bus.done = (state == SER_DONE);

    // Store bytes picked from the element's bank and slot
    assign bank_word = ser_bus.vstore_data[lane];

    always_comb begin
        case (ser_bus.eew)
            EEW8: begin
                ser_bus.elem_store_data = {24'h0, bank_word[{ser_bus.slot, 3'b000} +: 8]};
                ser_bus.elem_load_type = ser_bus.vwen ? SB : LBU;
            end
            EEW16: begin
                ser_bus.elem_store_data = {16'h0, bank_word[{ser_bus.slot[0], 4'b0000} +: 16]};
                ser_bus.elem_load_type = ser_bus.vwen ? SH : LHU;
            end
            default: begin
                ser_bus.elem_store_data = bank_word;
                ser_bus.elem_load_type = ser_bus.vwen ? SW : LW;
            end
        endcase
    end

    // Loaded element goes to its own lane only
    always_comb begin
        ser_bus.lane_wen = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            ser_bus.lane_data[l] = (LANE_W'(l) == lane) ? ser_bus.elem_rdata : '0;
        end
        if (state == SER_WAIT && ser_bus.elem_done && ser_bus.vren) begin
            ser_bus.lane_wen[lane] = 1'b1;
        end
    end

    // Stage must not hand over more elements than one register holds
    a_vl_cap: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (state == SER_IDLE && ser_bus.start) |-> (ser_bus.vl <= vl_cap)
    ) else $error("vl %0d exceeds capacity %0d", ser_bus.vl, vl_cap);

endmodule

//--- hw/load_store_controller.sv
// One access at a time; addresses must be aligned to the access size, no misaligned split
`timescale 1ns/1ns

module load_store_controller (
    input logic CLK,
    input logic rst_n,
    lsc_if.lsc lsc_bus,
    output rv32v_mem_pkg::word_t bus_addr,
    output logic bus_ren,
    output logic bus_wen,
    output rv32v_mem_pkg::word_t bus_wdata,
    output logic [rv32v_mem_pkg::WORD_BYTES-1:0] bus_byte_en,
    input rv32v_mem_pkg::word_t bus_rdata,
    input logic bus_busy
);
    import rv32v_mem_pkg::*;

    lsc_state_e state;
    logic req_ren;
    logic req_wen;
    word_t req_addr;
    word_t req_data;
    load_type_e req_type;
    word_t load_data;
    logic [1:0] byte_off;
    logic [WORD_BYTES-1:0] size_mask;
    word_t rdata_shift;
    word_t rdata_ext;
    logic req_aligned;

    assign byte_off = req_addr[1:0];

    // Control state
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSC_IDLE;
            req_ren <= 1'b0;
            req_wen <= 1'b0;
        end else begin
            case (state)
                LSC_IDLE: begin
                    // Requests seen during the done cycle are ignored
                    if (lsc_bus.ren || lsc_bus.wen) begin
                        req_ren <= lsc_bus.ren;
                        req_wen <= lsc_bus.wen;
                        state <= LSC_BUS;
                    end
                end
                LSC_BUS: if (!bus_busy) state <= LSC_DONE;
                default: state <= LSC_IDLE;
            endcase
        end
    end

    // Latched request and captured load data
    always_ff @(posedge CLK) begin
        if (state == LSC_IDLE && (lsc_bus.ren || lsc_bus.wen)) begin
            req_addr <= lsc_bus.addr;
            req_data <= lsc_bus.store_data;
            req_type <= lsc_bus.load_type;
        end
        if (state == LSC_BUS && !bus_busy) begin
            load_data <= rdata_ext;
        end
    end

    // Bytes touched by the access size
    always_comb begin
        case (req_type)
            LB, LBU, SB: size_mask = 4'b0001;
            LH, LHU, SH: size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign bus_addr = req_addr;
    assign bus_ren = (state == LSC_BUS) & req_ren;
    assign bus_wen = (state == LSC_BUS) & req_wen;
    assign bus_byte_en = (state == LSC_BUS) ? (size_mask << byte_off) : '0;
    assign bus_wdata = req_data << {byte_off, 3'b000};

    // Addressed bytes moved down, then extended
    assign rdata_shift = bus_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (req_type)
            LB: rdata_ext = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            LH: rdata_ext = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            LBU: rdata_ext = {24'h0, rdata_shift[7:0]};
            LHU: rdata_ext = {16'h0, rdata_shift[15:0]};
            default: rdata_ext = rdata_shift;
        endcase
    end

    assign lsc_bus.dload_ext = load_data;
    assign lsc_bus.done = (state == LSC_DONE);

    always_comb begin
        case (lsc_bus.load_type)
            LH, LHU, SH: req_aligned = ~lsc_bus.addr[0];
            LW, SW: req_aligned = (lsc_bus.addr[1:0] == 2'b00);
            default: req_aligned = 1'b1;
        endcase
    end

    // Both the scalar and the element paths must present aligned addresses
    a_aligned: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (state == LSC_IDLE && (lsc_bus.ren || lsc_bus.wen)) |-> req_aligned
    ) else $error("misaligned access at %h", lsc_bus.addr);

    // Arbiter never mixes a read and a write
    a_rw_excl: assert property (
        @(posedge CLK) disable iff (!rst_n) !(lsc_bus.ren && lsc_bus.wen)
    ) else $error("ren and wen high together");

endmodule

//--- hw/write_xbar.sv
// Combinational; slot is counted in eew units and byte enables are zero without lane_wen
`timescale 1ns/1ns

module write_xbar (
    input rv32v_mem_pkg::word_t lane_data,
    input logic lane_wen,
    input rv32v_mem_pkg::eew_e eew,
    input logic [rv32v_mem_pkg::SLOT_W-1:0] slot,
    output rv32v_mem_pkg::word_t vwdata,
    output logic [rv32v_mem_pkg::WORD_BYTES-1:0] byte_en
);
    import rv32v_mem_pkg::*;

    logic [WORD_BYTES-1:0] slot_mask;

    // Element copied into every slot, enables pick one
    always_comb begin
        case (eew)
            EEW8: begin
                vwdata = {4{lane_data[7:0]}};
                slot_mask = 4'b0001 << slot;
            end
            EEW16: begin
                vwdata = {2{lane_data[15:0]}};
                // Only slot bit 0 is meaningful here
                slot_mask = 4'b0011 << {slot[0], 1'b0};
            end
            default: begin
                vwdata = lane_data;
                slot_mask = 4'b1111;
            end
        endcase
    end

    assign byte_en = lane_wen ? slot_mask : '0;

endmodule

//--- hw/mem_stage.sv
// Vector request takes the bus whenever vren or vwen is high; inputs must be held until done
`timescale 1ns/1ns

module mem_stage (
    input logic CLK,
    input logic rst_n,
    // Scalar op from execute
    input logic valid,
    input logic dren,
    input logic dwen,
    input rv32v_mem_pkg::load_type_e load_type,
    input rv32v_mem_pkg::word_t addr,
    input rv32v_mem_pkg::word_t store_data,
    input rv32v_mem_pkg::wsel_e w_sel,
    input rv32v_mem_pkg::word_t pc4,
    input rv32v_mem_pkg::word_t imm_u,
    // Vector op from execute
    input logic vren,
    input logic vwen,
    input rv32v_mem_pkg::word_t vbase,
    input rv32v_mem_pkg::eew_e veew,
    input logic [rv32v_mem_pkg::VL_W-1:0] vl,
    input rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0] vstore_data,
    // Writeback
    output rv32v_mem_pkg::word_t reg_wdata,
    output logic done,
    output logic stall,
    output logic vwb_valid,
    output rv32v_mem_pkg::word_t [rv32v_mem_pkg::NUM_LANES-1:0] vwdata,
    output logic [rv32v_mem_pkg::NUM_LANES-1:0][rv32v_mem_pkg::WORD_BYTES-1:0] vbyte_wen,
    // Data bus
    output rv32v_mem_pkg::word_t bus_addr,
    output logic bus_ren,
    output logic bus_wen,
    output rv32v_mem_pkg::word_t bus_wdata,
    output logic [rv32v_mem_pkg::WORD_BYTES-1:0] bus_byte_en,
    input rv32v_mem_pkg::word_t bus_rdata,
    input logic bus_busy
);
    import rv32v_mem_pkg::*;

    logic vmemop;
    logic smemop;

    lsc_if lsc_bus ();
    serial_if ser_bus ();

    assign vmemop = vren | vwen;
    assign smemop = valid & (dren | dwen);

    // Arbiter, vector elements win while a vector op is present
    assign lsc_bus.ren = vmemop ? ser_bus.elem_ren : (valid & dren);
    assign lsc_bus.wen = vmemop ? ser_bus.elem_wen : (valid & dwen);
    assign lsc_bus.addr = vmemop ? ser_bus.elem_addr : addr;
    assign lsc_bus.store_data = vmemop ? ser_bus.elem_store_data : store_data;
    assign lsc_bus.load_type = vmemop ? ser_bus.elem_load_type : load_type;

    // Serializer operands straight from execute
    assign ser_bus.start = vmemop;
    assign ser_bus.vren = vren;
    assign ser_bus.vwen = vwen;
    assign ser_bus.base = vbase;
    assign ser_bus.eew = veew;
    assign ser_bus.vl = vl;
    assign ser_bus.vstore_data = vstore_data;
    assign ser_bus.elem_done = vmemop & lsc_bus.done;
    assign ser_bus.elem_rdata = lsc_bus.dload_ext;

    mem_serializer u_ser (
        .CLK,
        .rst_n,
        .ser_bus
    );

    load_store_controller u_lsc (
        .CLK,
        .rst_n,
        .lsc_bus,
        .bus_addr,
        .bus_ren,
        .bus_wen,
        .bus_wdata,
        .bus_byte_en,
        .bus_rdata,
        .bus_busy
    );

    // Scalar writeback select
    always_comb begin
        case (w_sel)
            WSEL_LOAD: reg_wdata = lsc_bus.dload_ext;
            WSEL_PC4: reg_wdata = pc4;
            WSEL_IMMU: reg_wdata = imm_u;
            default: reg_wdata = addr;
        endcase
    end

    // Non-memory ops finish in the cycle they arrive
    assign done = vmemop ? ser_bus.done : (smemop ? lsc_bus.done : valid);
    assign stall = vmemop ? ~ser_bus.done : (smemop & ~lsc_bus.done);
    assign vwb_valid = |ser_bus.lane_wen;

    // One write crossbar per register bank
    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : gen_wb_xbar
            write_xbar u_xbar (
                .lane_data(ser_bus.lane_data[i]),
                .lane_wen(ser_bus.lane_wen[i]),
                .eew(veew),
                .slot(ser_bus.slot),
                .vwdata(vwdata[i]),
                .byte_en(vbyte_wen[i])
            );
        end
    endgenerate

    // Execute must never hand over both kinds of memory op at once
    a_one_source: assert property (
        @(posedge CLK) disable iff (!rst_n) !(smemop && vmemop)
    ) else $error("scalar and vector memory requests together");

endmodule

//--- dv/mem_stage_tb.sv
// Bus model holds 256 bytes and wraps above address bit 7; each table row is held until done
`timescale 1ns/1ns

module mem_stage_tb;
    import rv32v_mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY = 2;
    localparam int BUS_DLY = 1;
    localparam int NUM_ENTRIES = 28;

    typedef enum logic [2:0] {
        K_NONMEM,
        K_LOAD,
        K_STORE,
        K_VLOAD,
        K_VSTORE
    } kind_e;

    // One stimulus row and its expected scalar result
    typedef struct packed {
        kind_e kind;
        load_type_e ltype;
        wsel_e wsel;
        word_t addr;
        word_t data;
        eew_e eew;
        logic [VL_W-1:0] vl;
        word_t exp_wdata;
    } entry_t;

    logic CLK;
    logic rst_n;
    logic valid;
    logic dren;
    logic dwen;
    load_type_e load_type;
    word_t addr;
    word_t store_data;
    wsel_e w_sel;
    word_t pc4;
    word_t imm_u;
    logic vren;
    logic vwen;
    word_t vbase;
    eew_e veew;
    logic [VL_W-1:0] vl;
    word_t [NUM_LANES-1:0] vstore_data;
    word_t reg_wdata;
    logic done;
    logic stall;
    logic vwb_valid;
    word_t [NUM_LANES-1:0] vwdata;
    logic [NUM_LANES-1:0][WORD_BYTES-1:0] vbyte_wen;
    word_t bus_addr;
    logic bus_ren;
    logic bus_wen;
    word_t bus_wdata;
    logic [WORD_BYTES-1:0] bus_byte_en;
    word_t bus_rdata;
    logic bus_busy;

    entry_t tbl [NUM_ENTRIES];
    logic [7:0] mem [256];
    logic [7:0] ref_mem [256];
    // Vector register model and the bytes written into it
    word_t vreg [NUM_LANES];
    logic [WORD_BYTES-1:0] wr_mask [NUM_LANES];
    logic [31:0] lfsr_state;
    int errors;
    int checks;
    int cyc = 0;
    // Expected access shape, set per row
    word_t exp_base;
    int exp_size;
    logic exp_write;
    int n_start;
    // Written by the bus model only
    int n_access = 0;
    int last_accept = 0;

    mem_stage DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK) cyc <= cyc + 1;

    // Word read straight from the addressed row
    assign bus_rdata = {mem[{bus_addr[7:2], 2'd3}], mem[{bus_addr[7:2], 2'd2}],
                        mem[{bus_addr[7:2], 2'd1}], mem[{bus_addr[7:2], 2'd0}]};

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic int access_bytes(input load_type_e t);
        case (t)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic int eew_bytes(input eew_e w);
        return (w == EEW8) ? 1 : ((w == EEW16) ? 2 : 4);
    endfunction

    function automatic logic [3:0] byte_mask(input int nbytes, input logic [1:0] off);
        logic [3:0] m;
        m = (nbytes == 1) ? 4'b0001 : ((nbytes == 2) ? 4'b0011 : 4'b1111);
        return m << off;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_table();
        tbl[0] = '{K_STORE, SW, WSEL_LOAD, 32'h40, 32'h8a7b_6c5d, EEW8, 5'd0, 32'h0};
        tbl[1] = '{K_LOAD, LW, WSEL_LOAD, 32'h40, 32'h0, EEW8, 5'd0, 32'h8a7b_6c5d};
        tbl[2] = '{K_LOAD, LB, WSEL_LOAD, 32'h43, 32'h0, EEW8, 5'd0, 32'hffff_ff8a};
        tbl[3] = '{K_LOAD, LBU, WSEL_LOAD, 32'h43, 32'h0, EEW8, 5'd0, 32'h0000_008a};
        tbl[4] = '{K_LOAD, LH, WSEL_LOAD, 32'h42, 32'h0, EEW8, 5'd0, 32'hffff_8a7b};
        tbl[5] = '{K_LOAD, LHU, WSEL_LOAD, 32'h42, 32'h0, EEW8, 5'd0, 32'h0000_8a7b};
        tbl[6] = '{K_STORE, SB, WSEL_LOAD, 32'h41, 32'h0000_00ee, EEW8, 5'd0, 32'h0};
        tbl[7] = '{K_LOAD, LW, WSEL_LOAD, 32'h40, 32'h0, EEW8, 5'd0, 32'h8a7b_ee5d};
        tbl[8] = '{K_STORE, SH, WSEL_LOAD, 32'h42, 32'h0000_1234, EEW8, 5'd0, 32'h0};
        tbl[9] = '{K_LOAD, LW, WSEL_LOAD, 32'h40, 32'h0, EEW8, 5'd0, 32'h1234_ee5d};
        // Untouched fill bytes
        tbl[10] = '{K_LOAD, LW, WSEL_LOAD, 32'h10, 32'h0, EEW8, 5'd0, 32'hb6b7_b4b5};
        tbl[11] = '{K_LOAD, LB, WSEL_LOAD, 32'h13, 32'h0, EEW8, 5'd0, 32'hffff_ffb6};
        tbl[12] = '{K_LOAD, LHU, WSEL_LOAD, 32'h10, 32'h0, EEW8, 5'd0, 32'h0000_b4b5};
        tbl[13] = '{K_LOAD, LB, WSEL_LOAD, 32'h81, 32'h0, EEW8, 5'd0, 32'h0000_0024};
        tbl[14] = '{K_LOAD, LH, WSEL_LOAD, 32'h82, 32'h0, EEW8, 5'd0, 32'h0000_2627};
        // pc4 takes data, imm_u its inverse
        tbl[15] = '{K_NONMEM, LW, WSEL_PC4, 32'h1234, 32'h0104, EEW8, 5'd0, 32'h0000_0104};
        tbl[16] = '{K_NONMEM, LW, WSEL_IMMU, 32'h1234, 32'h0fff, EEW8, 5'd0, 32'hffff_f000};
        tbl[17] = '{K_NONMEM, LW, WSEL_ALU, 32'h0bad_0c0d, 32'h0, EEW8, 5'd0, 32'h0bad_0c0d};
        tbl[18] = '{K_VLOAD, LW, WSEL_LOAD, 32'h00, 32'h0, EEW8, 5'd16, 32'h0};
        tbl[19] = '{K_VLOAD, LW, WSEL_LOAD, 32'h20, 32'h0, EEW16, 5'd5, 32'h0};
        tbl[20] = '{K_VLOAD, LW, WSEL_LOAD, 32'h50, 32'h0, EEW32, 5'd4, 32'h0};
        tbl[21] = '{K_VLOAD, LW, WSEL_LOAD, 32'h60, 32'h0, EEW8, 5'd0, 32'h0};
        tbl[22] = '{K_VSTORE, LW, WSEL_LOAD, 32'hc0, 32'h0, EEW8, 5'd9, 32'h0};
        tbl[23] = '{K_VSTORE, LW, WSEL_LOAD, 32'hd0, 32'h0, EEW16, 5'd8, 32'h0};
        tbl[24] = '{K_VSTORE, LW, WSEL_LOAD, 32'he0, 32'h0, EEW32, 5'd3, 32'h0};
        // Read back what the vector store left
        tbl[25] = '{K_VLOAD, LW, WSEL_LOAD, 32'hd0, 32'h0, EEW16, 5'd8, 32'h0};
        tbl[26] = '{K_VLOAD, LW, WSEL_LOAD, 32'h90, 32'h0, EEW8, 5'd7, 32'h0};
        tbl[27] = '{K_VSTORE, LW, WSEL_LOAD, 32'hf0, 32'h0, EEW8, 5'd0, 32'h0};
    endtask

    task automatic set_idle();
        valid = 1'b0;
        dren = 1'b0;
        dwen = 1'b0;
        load_type = LW;
        addr = '0;
        store_data = '0;
        w_sel = WSEL_LOAD;
        pc4 = '0;
        imm_u = '0;
        vren = 1'b0;
        vwen = 1'b0;
        vbase = '0;
        veew = EEW8;
        vl = '0;
        vstore_data = '0;
    endtask

    task automatic drive_entry(input entry_t e);
        valid = (e.kind == K_NONMEM) || (e.kind == K_LOAD) || (e.kind == K_STORE);
        dren = (e.kind == K_LOAD);
        dwen = (e.kind == K_STORE);
        load_type = e.ltype;
        addr = e.addr;
        store_data = e.data;
        w_sel = e.wsel;
        pc4 = e.data;
        imm_u = ~e.data;
        vren = (e.kind == K_VLOAD);
        vwen = (e.kind == K_VSTORE);
        vbase = e.addr;
        veew = e.eew;
        vl = e.vl;
        for (int b = 0; b < NUM_LANES; b++) begin
            vstore_data[b] = (e.kind == K_VSTORE) ? rand_bits(32) : '0;
            vreg[b] = '0;
            wr_mask[b] = '0;
        end
        exp_base = e.addr;
        exp_size = (vren || vwen) ? eew_bytes(e.eew) : access_bytes(e.ltype);
        exp_write = dwen || vwen;
        n_start = n_access;
    endtask

    // Mapping rule per element: stores update the reference, loads check the model
    task automatic walk_elements(input entry_t e);
        logic [WORD_BYTES-1:0] exp_mask [NUM_LANES];
        int esize;
        int lane;
        int off;
        logic [7:0] maddr;
        esize = eew_bytes(e.eew);
        for (int b = 0; b < NUM_LANES; b++) exp_mask[b] = '0;
        for (int i = 0; i < int'(e.vl); i++) begin
            lane = i % NUM_LANES;
            for (int k = 0; k < esize; k++) begin
                off = (i / NUM_LANES) * esize + k;
                maddr = e.addr[7:0] + 8'(i * esize + k);
                exp_mask[lane][off] = 1'b1;
                if (e.kind == K_VSTORE) begin
                    ref_mem[maddr] = vstore_data[lane][8*off +: 8];
                end else begin
                    check_value($sformatf("vreg[%0d] byte %0d", lane, off),
                                32'(vreg[lane][8*off +: 8]), 32'(ref_mem[maddr]));
                end
            end
        end
        if (e.kind == K_VLOAD) begin
            for (int b = 0; b < NUM_LANES; b++) begin
                check_value($sformatf("vbyte_wen[%0d] total", b),
                            32'(wr_mask[b]), 32'(exp_mask[b]));
            end
        end
    endtask

    task automatic compare_memory();
        for (int a = 0; a < 256; a++) begin
            check_value($sformatf("mem[%h]", 8'(a)), 32'(mem[a]), 32'(ref_mem[a]));
        end
    endtask

    // Bus slave with random wait states
    initial begin : bus_model
        int busy_left;
        logic in_access;
        word_t held_addr;
        word_t held_wdata;
        logic [3:0] held_be;
        word_t exp_addr;
        bus_busy = 1'b0;
        in_access = 1'b0;
        busy_left = 0;
        forever begin
            @(posedge CLK);
            #(BUS_DLY);
            if (rst_n && (bus_ren || bus_wen) && !in_access) begin
                in_access = 1'b1;
                busy_left = int'(rand_bits(2));
                held_addr = bus_addr;
                held_wdata = bus_wdata;
                held_be = bus_byte_en;
                exp_addr = exp_base + 32'((n_access - n_start) * exp_size);
                check_value("bus_addr", bus_addr, exp_addr);
                check_value("bus_byte_en", 32'(bus_byte_en),
                            32'(byte_mask(exp_size, exp_addr[1:0])));
                check_value("bus_wen", 32'(bus_wen), 32'(exp_write));
                n_access++;
            end
            bus_busy = in_access && (busy_left != 0);
            @(negedge CLK);
            if (in_access) begin
                // Request must not move while waiting
                check_value("bus_addr held", bus_addr, held_addr);
                check_value("bus_wdata held", bus_wdata, held_wdata);
                check_value("bus_byte_en held", 32'(bus_byte_en), 32'(held_be));
                check_value("bus request held", 32'(bus_ren || bus_wen), 32'd1);
                if (bus_busy) begin
                    busy_left--;
                end else begin
                    for (int k = 0; k < WORD_BYTES; k++) begin
                        if (bus_wen && bus_byte_en[k]) begin
                            mem[{bus_addr[7:2], 2'(k)}] = bus_wdata[8*k +: 8];
                        end
                    end
                    last_accept = cyc;
                    in_access = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        entry_t e;
        int ncyc;
        int banks;
        errors = 0;
        checks = 0;
        lfsr_state = 32'hd177_68ba;
        rst_n = 1'b0;
        set_idle();
        load_table();
        // Fill depends on every address bit
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a) ^ 8'ha5;
            ref_mem[a] = 8'(a) ^ 8'ha5;
        end
        repeat (3) @(posedge CLK);
        #(DRV_DLY);
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("vwb_valid after reset", 32'(vwb_valid), 32'd0);
        check_value("bus_ren after reset", 32'(bus_ren), 32'd0);
        check_value("bus_wen after reset", 32'(bus_wen), 32'd0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = tbl[i];
            @(posedge CLK);
            #(DRV_DLY);
            drive_entry(e);
            ncyc = 0;
            do begin
                @(negedge CLK);
                ncyc++;
                if (vwb_valid) begin
                    banks = 0;
                    for (int b = 0; b < NUM_LANES; b++) begin
                        if (vbyte_wen[b] != '0) banks++;
                        for (int k = 0; k < WORD_BYTES; k++) begin
                            if (vbyte_wen[b][k]) begin
                                vreg[b][8*k +: 8] = vwdata[b][8*k +: 8];
                                wr_mask[b][k] = 1'b1;
                            end
                        end
                    end
                    check_value("banks per vwb_valid", 32'(banks), 32'd1);
                end
                check_value("stall", 32'(stall), 32'(e.kind != K_NONMEM && !done));
            end while (!done);
            case (e.kind)
                K_NONMEM: begin
                    check_value("done latency", 32'(ncyc), 32'd1);
                    check_value("bus_ren", 32'(bus_ren), 32'd0);
                    check_value("bus_wen", 32'(bus_wen), 32'd0);
                    check_value("reg_wdata", reg_wdata, e.exp_wdata);
                end
                K_LOAD, K_STORE: begin
                    check_value("bus accesses", 32'(n_access - n_start), 32'd1);
                    check_value("done cycle", 32'(cyc), 32'(last_accept + 1));
                    if (e.kind == K_LOAD) begin
                        check_value("reg_wdata", reg_wdata, e.exp_wdata);
                    end else begin
                        for (int k = 0; k < access_bytes(e.ltype); k++) begin
                            ref_mem[e.addr[7:0] + 8'(k)] = e.data[8*k +: 8];
                        end
                        compare_memory();
                    end
                end
                default: begin
                    check_value("bus accesses", 32'(n_access - n_start), 32'(e.vl));
                    if (e.vl == '0) begin
                        check_value("done latency", 32'(ncyc), 32'd3);
                    end else begin
                        check_value("done cycle", 32'(cyc), 32'(last_accept + 2));
                    end
                    walk_elements(e);
                    if (e.kind == K_VSTORE) compare_memory();
                end
            endcase
        end
        @(posedge CLK);
        #(DRV_DLY);
        set_idle();
        @(posedge CLK);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget covers a full-length vector with worst wait states per row
    initial begin : watchdog
        repeat (NUM_ENTRIES * (VLMAX + 1) * 6 + 10) @(posedge CLK);
        $display("Timeout: the test table did not finish within its cycle budget");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
hw/rv32v_mem_pkg.sv
hw/lsc_if.sv
hw/serial_if.sv
hw/mem_serializer.sv
hw/load_store_controller.sv
hw/write_xbar.sv
hw/mem_stage.sv
dv/mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and judges the result from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sim.f --top-module mem_stage_tb --Mdir "$BUILD_DIR" -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mem_stage_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
